/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_rename_unit
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= *** PASSED ***

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

/* build.f */
logic/rename_cfg_pkg.sv
logic/rename_types_pkg.sv
logic/rename_commit_if.sv
logic/rename_freelist.sv
logic/rename_map_table.sv
logic/rename_commit_map.sv
logic/rename_commit_ctrl.sv
logic/rename_bypass_stage.sv
logic/rename_unit.sv
testbench/tb_clock_gen.sv
testbench/tb_rename_unit.sv

/* logic/rename_bypass_stage.sv */
// ------------------------------------------------
// in-group dependency bypass
// destination ID select and output register
// ------------------------------------------------

`timescale 1ns/1ps

module rename_bypass_stage (
  input  logic                                                  i_clk,
  input  logic                                                  i_reset_n,
  input  logic                                                  i_fire,
  input  logic [rename_cfg_pkg::LANES-1:0]                        i_rd_valid,
  input  rename_types_pkg::arch_idx_t [rename_cfg_pkg::LANES-1:0] i_rd_idx,
  input  rename_types_pkg::arch_idx_t [rename_cfg_pkg::LANES-1:0] i_rs1_idx,
  input  rename_types_pkg::arch_idx_t [rename_cfg_pkg::LANES-1:0] i_rs2_idx,
  input  rename_types_pkg::rnid_t [rename_cfg_pkg::LANES-1:0]     i_new_rnid,
  input  rename_types_pkg::rnid_t [rename_cfg_pkg::LANES-1:0]     i_map_rs1,
  input  rename_types_pkg::rnid_t [rename_cfg_pkg::LANES-1:0]     i_map_rs2,
  input  rename_types_pkg::rnid_t [rename_cfg_pkg::LANES-1:0]     i_map_old,
  output logic                                                  o_valid,
  output rename_types_pkg::rnid_t [rename_cfg_pkg::LANES-1:0]     o_rd_rnid,
  output rename_types_pkg::rnid_t [rename_cfg_pkg::LANES-1:0]     o_rd_old_rnid,
  output rename_types_pkg::rnid_t [rename_cfg_pkg::LANES-1:0]     o_rs1_rnid,
  output rename_types_pkg::rnid_t [rename_cfg_pkg::LANES-1:0]     o_rs2_rnid
);
  import rename_cfg_pkg::*;
  import rename_types_pkg::*;

  logic [LANES-1:0]  w_writes;  // lane renames a nonzero register
  rnid_t [LANES-1:0] w_rd;
  rnid_t [LANES-1:0] w_old;
  rnid_t [LANES-1:0] w_rs1;
  rnid_t [LANES-1:0] w_rs2;

  // ------------------------------------------------
  // bypass from older lanes in the group
  // ------------------------------------------------
  always_comb begin
    for (int l = 0; l < LANES; l++) begin
      w_writes[l] = i_rd_valid[l] & (i_rd_idx[l] != '0);
      w_rd[l]     = w_writes[l] ? i_new_rnid[l] : '0;  // r0 or no dest gets ID 0
      w_rs1[l]    = i_map_rs1[l];
      w_rs2[l]    = i_map_rs2[l];
      w_old[l]    = i_map_old[l];
      // youngest older writer wins
      for (int p = 0; p < l; p++) begin
        if (w_writes[p]) begin
          if (i_rs1_idx[l] == i_rd_idx[p]) begin
            w_rs1[l] = i_new_rnid[p];
          end
          if (i_rs2_idx[l] == i_rd_idx[p]) begin
            w_rs2[l] = i_new_rnid[p];
          end
          if (i_rd_idx[l] == i_rd_idx[p]) begin
            w_old[l] = i_new_rnid[p];
          end
        end
      end
    end
  end

  // ------------------------------------------------
  // output register
  // ------------------------------------------------
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      o_valid <= 1'b0;
    end else begin
      o_valid <= i_fire;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_fire) begin
      o_rd_rnid     <= w_rd;
      o_rd_old_rnid <= w_old;
      o_rs1_rnid    <= w_rs1;
      o_rs2_rnid    <= w_rs2;
    end
  end

endmodule

/* logic/rename_cfg_pkg.sv */
// ------------------------------------------------
// sizes and widths of the rename stage
// lane count, register counts, ID widths
// ------------------------------------------------

package rename_cfg_pkg;

  // ------------------------------------------------
  // group shape
  // ------------------------------------------------
  localparam int LANES = 2;      // instructions per group

  // ------------------------------------------------
  // register spaces
  // ------------------------------------------------
  localparam int ARCH_REGS = 32;
  localparam int ARCH_W    = 5;  // log2 of ARCH_REGS
  localparam int RNID_W    = 7;  // up to 128 physical IDs

  // default free-list depth for each lane
  localparam int FLIST_DEPTH_DEF = 16;

endpackage

/* logic/rename_commit_ctrl.sv */
// ------------------------------------------------
// commit staging register
// exception detect and restore sequencing
// ------------------------------------------------

`timescale 1ns/1ps

module rename_commit_ctrl (
  input  logic                                                   i_clk,
  input  logic                                                   i_reset_n,
  input  logic                                                   i_cmt_valid,
  input  rename_types_pkg::cmt_lane_t [rename_cfg_pkg::LANES-1:0] i_cmt_lanes,
  output logic                                                   o_flush_busy,
  rename_commit_if.ctrl                                          cmt
);
  import rename_cfg_pkg::*;
  import rename_types_pkg::*;

  logic w_in_except;     // exception arriving now
  logic w_stage_except;  // exception in the staged commit

  always_comb begin
    w_in_except    = 1'b0;
    w_stage_except = 1'b0;
    for (int l = 0; l < LANES; l++) begin
      if (i_cmt_lanes[l].kind == CMT_EXCEPT) begin
        w_in_except = i_cmt_valid;
      end
      if (cmt.lanes[l].kind == CMT_EXCEPT) begin
        w_stage_except = cmt.upd_valid;
      end
    end
  end

  // rename stalls from the exception until the reload edge
  assign o_flush_busy = w_in_except | w_stage_except | cmt.restore;

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      cmt.upd_valid <= 1'b0;
      cmt.restore   <= 1'b0;
    end else begin
      cmt.upd_valid <= i_cmt_valid;
      cmt.restore   <= w_stage_except;  // one edge after the update
    end
  end

  always_ff @(posedge i_clk) begin
    cmt.lanes <= i_cmt_lanes;
  end

endmodule

/* logic/rename_commit_if.sv */
// ------------------------------------------------
// staged commit update bus
// commit control to free lists and both maps
// ------------------------------------------------

`timescale 1ns/1ps

interface rename_commit_if;
  import rename_cfg_pkg::*;
  import rename_types_pkg::*;

  logic                         upd_valid;  // staged commit this cycle
  cmt_lane_t [LANES-1:0]        lanes;
  logic                         restore;    // map table reload from commit map

  modport ctrl (
    output upd_valid,
    output lanes,
    output restore
  );

  // each free list picks its own lane out of lanes
  modport flist (
    input upd_valid,
    input lanes
  );

  modport cmap (
    input upd_valid,
    input lanes
  );

  modport map (
    input restore
  );

endinterface

/* logic/rename_commit_map.sv */
// ------------------------------------------------
// committed arch to physical map
// source for the exception restore
// ------------------------------------------------

`timescale 1ns/1ps

module rename_commit_map (
  input  logic                    i_clk,
  input  logic                    i_reset_n,
  rename_commit_if.cmap           cmt,
  output rename_types_pkg::rnid_t o_map [rename_cfg_pkg::ARCH_REGS]
);
  import rename_cfg_pkg::*;
  import rename_types_pkg::*;

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      for (int r = 0; r < ARCH_REGS; r++) begin
        o_map[r] <= rnid_t'(r);
      end
    end else if (cmt.upd_valid) begin
      for (int l = 0; l < LANES; l++) begin
        // only normal retires become architectural
        if (cmt.lanes[l].rd_valid && (cmt.lanes[l].kind == CMT_NORMAL) &&
            (cmt.lanes[l].rd_idx != '0)) begin
          o_map[cmt.lanes[l].rd_idx] <= cmt.lanes[l].new_rnid;
        end
      end
    end
  end

endmodule

/* logic/rename_freelist.sv */
// ------------------------------------------------
// free physical ID FIFO for one lane
// circular buffer with head, tail and count
// ------------------------------------------------

`timescale 1ns/1ps

module rename_freelist #(
  parameter int DEPTH     = 16,
  parameter int INIT_BASE = 32
) (
  input  logic                    i_clk,
  input  logic                    i_reset_n,
  input  logic                    i_pop,
  output rename_types_pkg::rnid_t o_pop_id,
  output logic                    o_empty,
  rename_commit_if.flist          cmt
);
  import rename_cfg_pkg::*;
  import rename_types_pkg::*;

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);
  localparam int LANE  = (INIT_BASE - ARCH_REGS) / DEPTH;  // lane served by this list

  rnid_t            r_ids [DEPTH];
  logic [PTR_W-1:0] r_head;
  logic [PTR_W-1:0] r_tail;
  logic [CNT_W-1:0] r_count;
  logic             w_pop;
  logic             w_push;
  rnid_t            w_push_id;
  cmt_lane_t        w_lane;

  assign w_lane   = cmt.lanes[LANE];
  assign w_push   = cmt.upd_valid & w_lane.rd_valid & (w_lane.rd_idx != '0);
  // normal retire frees the old ID, anything else frees its own
  assign w_push_id = (w_lane.kind == CMT_NORMAL) ? w_lane.old_rnid : w_lane.new_rnid;

  assign o_empty  = (r_count == '0);
  assign w_pop    = i_pop & ~o_empty;
  assign o_pop_id = r_ids[r_head];

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      for (int i = 0; i < DEPTH; i++) begin
        r_ids[i] <= rnid_t'(INIT_BASE + i);  // ascending from INIT_BASE
      end
      r_head  <= '0;
      r_tail  <= '0;
      r_count <= CNT_W'(DEPTH);
    end else begin
      if (w_pop) begin
        r_head <= (r_head == PTR_W'(DEPTH - 1)) ? '0 : r_head + PTR_W'(1);
      end
      if (w_push) begin
        r_ids[r_tail] <= w_push_id;
        r_tail <= (r_tail == PTR_W'(DEPTH - 1)) ? '0 : r_tail + PTR_W'(1);
      end
      if (w_push && !w_pop) begin
        r_count <= r_count + CNT_W'(1);
      end else if (w_pop && !w_push) begin
        r_count <= r_count - CNT_W'(1);
      end
    end
  end

endmodule

/* logic/rename_map_table.sv */
// ------------------------------------------------
// speculative arch to physical map
// combinational reads, lane-ordered writes,
// full reload on exception restore
// ------------------------------------------------

`timescale 1ns/1ps

module rename_map_table (
  input  logic                                                  i_clk,
  input  logic                                                  i_reset_n,
  input  rename_types_pkg::arch_idx_t [rename_cfg_pkg::LANES-1:0] i_rs1_idx,
  input  rename_types_pkg::arch_idx_t [rename_cfg_pkg::LANES-1:0] i_rs2_idx,
  input  rename_types_pkg::arch_idx_t [rename_cfg_pkg::LANES-1:0] i_rd_idx,
  output rename_types_pkg::rnid_t [rename_cfg_pkg::LANES-1:0]     o_rs1_rnid,
  output rename_types_pkg::rnid_t [rename_cfg_pkg::LANES-1:0]     o_rs2_rnid,
  output rename_types_pkg::rnid_t [rename_cfg_pkg::LANES-1:0]     o_rd_old_rnid,
  input  logic [rename_cfg_pkg::LANES-1:0]                        i_wr_en,
  input  rename_types_pkg::rnid_t [rename_cfg_pkg::LANES-1:0]     i_wr_rnid,
  input  rename_types_pkg::rnid_t i_restore_map [rename_cfg_pkg::ARCH_REGS],
  rename_commit_if.map                                            cmt
);
  import rename_cfg_pkg::*;
  import rename_types_pkg::*;

  rnid_t r_map [ARCH_REGS];

  // ------------------------------------------------
  // read ports
  // ------------------------------------------------
  always_comb begin
    for (int l = 0; l < LANES; l++) begin
      o_rs1_rnid[l]    = r_map[i_rs1_idx[l]];
      o_rs2_rnid[l]    = r_map[i_rs2_idx[l]];
      o_rd_old_rnid[l] = r_map[i_rd_idx[l]];
    end
  end

  // ------------------------------------------------
  // update
  // ------------------------------------------------
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      for (int r = 0; r < ARCH_REGS; r++) begin
        r_map[r] <= rnid_t'(r);  // identity
      end
    end else if (cmt.restore) begin
      r_map <= i_restore_map;  // wins over any write
    end else begin
      // later lane overwrites an earlier one on the same index
      for (int l = 0; l < LANES; l++) begin
        if (i_wr_en[l] && (i_rd_idx[l] != '0)) begin
          r_map[i_rd_idx[l]] <= i_wr_rnid[l];
        end
      end
    end
  end

endmodule

/* logic/rename_types_pkg.sv */
// ------------------------------------------------
// ID types for the rename stage
// commit kind enum, per-lane commit struct
// ------------------------------------------------

package rename_types_pkg;

  typedef logic [rename_cfg_pkg::ARCH_W-1:0] arch_idx_t;  // architectural index
  typedef logic [rename_cfg_pkg::RNID_W-1:0] rnid_t;      // physical ID

  // how an instruction left the window
  typedef enum logic [1:0] {
    CMT_NORMAL = 2'd0,  // retired normally
    CMT_DEAD   = 2'd1,  // squashed
    CMT_EXCEPT = 2'd2   // raised an exception
  } cmt_kind_e;

  // ------------------------------------------------
  // one lane of a commit, 22 bits
  // ------------------------------------------------
  typedef struct packed {
    logic      rd_valid;
    cmt_kind_e kind;
    arch_idx_t rd_idx;
    rnid_t     new_rnid;  // ID given at rename
    rnid_t     old_rnid;  // ID it replaced
  } cmt_lane_t;

endpackage

/* logic/rename_unit.sv */
// ------------------------------------------------
// two-lane integer register rename unit
// free lists, map tables, commit control,
// bypass and output stage
// ------------------------------------------------

`timescale 1ns/1ps

module rename_unit #(
  parameter int FLIST_DEPTH = rename_cfg_pkg::FLIST_DEPTH_DEF
) (
  input  logic                                                  i_clk,
  input  logic                                                  i_reset_n,
  // rename request
  input  logic                                                  i_valid,
  output logic                                                  o_ready,
  input  logic [rename_cfg_pkg::LANES-1:0]                        i_rd_valid,
  input  rename_types_pkg::arch_idx_t [rename_cfg_pkg::LANES-1:0] i_rd_idx,
  input  rename_types_pkg::arch_idx_t [rename_cfg_pkg::LANES-1:0] i_rs1_idx,
  input  rename_types_pkg::arch_idx_t [rename_cfg_pkg::LANES-1:0] i_rs2_idx,
  // commit
  input  logic                                                  i_cmt_valid,
  input  logic [rename_cfg_pkg::LANES-1:0]                        i_cmt_rd_valid,
  input  rename_types_pkg::cmt_kind_e [rename_cfg_pkg::LANES-1:0] i_cmt_kind,
  input  rename_types_pkg::arch_idx_t [rename_cfg_pkg::LANES-1:0] i_cmt_rd_idx,
  input  rename_types_pkg::rnid_t [rename_cfg_pkg::LANES-1:0]     i_cmt_new_rnid,
  input  rename_types_pkg::rnid_t [rename_cfg_pkg::LANES-1:0]     i_cmt_old_rnid,
  // renamed group
  output logic                                                  o_valid,
  output rename_types_pkg::rnid_t [rename_cfg_pkg::LANES-1:0]     o_rd_rnid,
  output rename_types_pkg::rnid_t [rename_cfg_pkg::LANES-1:0]     o_rd_old_rnid,
  output rename_types_pkg::rnid_t [rename_cfg_pkg::LANES-1:0]     o_rs1_rnid,
  output rename_types_pkg::rnid_t [rename_cfg_pkg::LANES-1:0]     o_rs2_rnid
);
  import rename_cfg_pkg::*;
  import rename_types_pkg::*;

  logic                  w_fire;
  logic                  w_flush_busy;
  logic [LANES-1:0]      w_empty;
  logic [LANES-1:0]      w_pop;      // also the map write enables
  rnid_t [LANES-1:0]     w_new_rnid;
  rnid_t [LANES-1:0]     w_map_rs1;
  rnid_t [LANES-1:0]     w_map_rs2;
  rnid_t [LANES-1:0]     w_map_old;
  rnid_t                 w_cmt_map [ARCH_REGS];
  cmt_lane_t [LANES-1:0] w_cmt_lanes;

  rename_commit_if u_cmt_if ();

  assign o_ready = ~w_flush_busy & ~(|w_empty);
  assign w_fire  = i_valid & o_ready;

  // ------------------------------------------------
  // per-lane free lists
  // ------------------------------------------------
  for (genvar l = 0; l < LANES; l++) begin : g_lane
    assign w_pop[l] = w_fire & i_rd_valid[l] & (i_rd_idx[l] != '0);

    assign w_cmt_lanes[l].rd_valid = i_cmt_rd_valid[l];
    assign w_cmt_lanes[l].kind     = i_cmt_kind[l];
    assign w_cmt_lanes[l].rd_idx   = i_cmt_rd_idx[l];
    assign w_cmt_lanes[l].new_rnid = i_cmt_new_rnid[l];
    assign w_cmt_lanes[l].old_rnid = i_cmt_old_rnid[l];

    rename_freelist #(
      .DEPTH     (FLIST_DEPTH),
      .INIT_BASE (ARCH_REGS + l * FLIST_DEPTH)
    ) u_freelist (
      .i_clk     (i_clk),
      .i_reset_n (i_reset_n),
      .i_pop     (w_pop[l]),
      .o_pop_id  (w_new_rnid[l]),
      .o_empty   (w_empty[l]),
      .cmt       (u_cmt_if.flist)
    );
  end

  // ------------------------------------------------
  // maps and commit path
  // ------------------------------------------------
  rename_map_table u_map_table (
    .i_clk         (i_clk),
    .i_reset_n     (i_reset_n),
    .i_rs1_idx     (i_rs1_idx),
    .i_rs2_idx     (i_rs2_idx),
    .i_rd_idx      (i_rd_idx),
    .o_rs1_rnid    (w_map_rs1),
    .o_rs2_rnid    (w_map_rs2),
    .o_rd_old_rnid (w_map_old),
    .i_wr_en       (w_pop),
    .i_wr_rnid     (w_new_rnid),
    .i_restore_map (w_cmt_map),
    .cmt           (u_cmt_if.map)
  );

  rename_commit_map u_commit_map (
    .i_clk     (i_clk),
    .i_reset_n (i_reset_n),
    .cmt       (u_cmt_if.cmap),
    .o_map     (w_cmt_map)
  );

  rename_commit_ctrl u_commit_ctrl (
    .i_clk        (i_clk),
    .i_reset_n    (i_reset_n),
    .i_cmt_valid  (i_cmt_valid),
    .i_cmt_lanes  (w_cmt_lanes),
    .o_flush_busy (w_flush_busy),
    .cmt          (u_cmt_if.ctrl)
  );

  rename_bypass_stage u_bypass (
    .i_clk         (i_clk),
    .i_reset_n     (i_reset_n),
    .i_fire        (w_fire),
    .i_rd_valid    (i_rd_valid),
    .i_rd_idx      (i_rd_idx),
    .i_rs1_idx     (i_rs1_idx),
    .i_rs2_idx     (i_rs2_idx),
    .i_new_rnid    (w_new_rnid),
    .i_map_rs1     (w_map_rs1),
    .i_map_rs2     (w_map_rs2),
    .i_map_old     (w_map_old),
    .o_valid       (o_valid),
    .o_rd_rnid     (o_rd_rnid),
    .o_rd_old_rnid (o_rd_old_rnid),
    .o_rs1_rnid    (o_rs1_rnid),
    .o_rs2_rnid    (o_rs2_rnid)
  );

endmodule

/* testbench/tb_clock_gen.sv */
// ------------------------------------------------
// testbench clock and reset source
// ------------------------------------------------

`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int PERIOD       = 20,
  parameter int RESET_CYCLES = 3
) (
  output logic o_clk,
  output logic o_reset_n
);

  initial begin
    o_clk     = 1'b0;
    o_reset_n = 1'b0;
    #(PERIOD * RESET_CYCLES) o_reset_n = 1'b1;  // lands on a falling edge
  end

  always #(PERIOD / 2) o_clk = ~o_clk;

endmodule

/* testbench/tb_rename_unit.sv */
// ------------------------------------------------
// testbench for the rename unit
// stimulus, reference model, assertions, watchdog
// ------------------------------------------------

`timescale 1ns/1ps

module tb_rename_unit;
  import rename_cfg_pkg::*;
  import rename_types_pkg::*;

  localparam int FLIST_DEPTH = FLIST_DEPTH_DEF;
  localparam int N_RANDOM    = 160;
  localparam int NUM_GROUPS  = N_RANDOM + 40;
  localparam int WATCHDOG_NS = (NUM_GROUPS + 20) * 20 * 4;

  logic                         i_clk;
  logic                         i_reset_n;
  logic                         i_valid;
  logic                         o_ready;
  logic [LANES-1:0]             i_rd_valid;
  arch_idx_t [LANES-1:0]        i_rd_idx;
  arch_idx_t [LANES-1:0]        i_rs1_idx;
  arch_idx_t [LANES-1:0]        i_rs2_idx;
  logic                         i_cmt_valid;
  logic [LANES-1:0]             i_cmt_rd_valid;
  cmt_kind_e [LANES-1:0]        i_cmt_kind;
  arch_idx_t [LANES-1:0]        i_cmt_rd_idx;
  rnid_t [LANES-1:0]            i_cmt_new_rnid;
  rnid_t [LANES-1:0]            i_cmt_old_rnid;
  logic                         o_valid;
  rnid_t [LANES-1:0]            o_rd_rnid;
  rnid_t [LANES-1:0]            o_rd_old_rnid;
  rnid_t [LANES-1:0]            o_rs1_rnid;
  rnid_t [LANES-1:0]            o_rs2_rnid;

  // ------------------------------------------------
  // reference model state
  // ------------------------------------------------
  rnid_t             smap [ARCH_REGS];      // speculative map
  rnid_t             cmap [ARCH_REGS];      // committed map
  int                fl_q [LANES][$];       // free IDs per lane
  logic [18:0]       out_q [LANES][$];      // outstanding {rd, new, old}
  logic              stg_valid;             // commit staged last edge
  logic              stg_exc;
  logic [LANES-1:0]  stg_rdv;
  cmt_kind_e         stg_kind [LANES];
  arch_idx_t         stg_rd [LANES];
  rnid_t             stg_new [LANES];
  rnid_t             stg_old [LANES];
  logic              rst_pend;              // map reload on next edge
  logic              mdl_ready;
  logic              exp_valid;
  rnid_t [LANES-1:0] exp_rd;
  rnid_t [LANES-1:0] exp_old;
  rnid_t [LANES-1:0] exp_rs1;
  rnid_t [LANES-1:0] exp_rs2;

  tb_clock_gen #(.PERIOD(20), .RESET_CYCLES(3)) u_clk_gen (
    .o_clk     (i_clk),
    .o_reset_n (i_reset_n)
  );

  rename_unit #(.FLIST_DEPTH(FLIST_DEPTH)) dut_i (
    .i_clk          (i_clk),
    .i_reset_n      (i_reset_n),
    .i_valid        (i_valid),
    .o_ready        (o_ready),
    .i_rd_valid     (i_rd_valid),
    .i_rd_idx       (i_rd_idx),
    .i_rs1_idx      (i_rs1_idx),
    .i_rs2_idx      (i_rs2_idx),
    .i_cmt_valid    (i_cmt_valid),
    .i_cmt_rd_valid (i_cmt_rd_valid),
    .i_cmt_kind     (i_cmt_kind),
    .i_cmt_rd_idx   (i_cmt_rd_idx),
    .i_cmt_new_rnid (i_cmt_new_rnid),
    .i_cmt_old_rnid (i_cmt_old_rnid),
    .o_valid        (o_valid),
    .o_rd_rnid      (o_rd_rnid),
    .o_rd_old_rnid  (o_rd_old_rnid),
    .o_rs1_rnid     (o_rs1_rnid),
    .o_rs2_rnid     (o_rs2_rnid)
  );

  task automatic report_bad_value(input string name, input logic [31:0] got,
                                  input logic [31:0] exp);
    $display("MISMATCH time=%0t signal=%s got=%h expected=%h", $time, name, got, exp);
    $display("*** FAILED ***");
    $fatal(1);
  endtask

  // ------------------------------------------------
  // checks, sampled at the rising edge
  // ------------------------------------------------
  a_ready: assert property (@(posedge i_clk) disable iff (!i_reset_n) o_ready == mdl_ready)
    else report_bad_value("o_ready", 32'($sampled(o_ready)), 32'($sampled(mdl_ready)));
  a_valid: assert property (@(posedge i_clk) disable iff (!i_reset_n) o_valid == exp_valid)
    else report_bad_value("o_valid", 32'($sampled(o_valid)), 32'($sampled(exp_valid)));
  a_rd: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    o_valid |-> o_rd_rnid == exp_rd)
    else report_bad_value("o_rd_rnid", 32'($sampled(o_rd_rnid)), 32'($sampled(exp_rd)));
  a_old: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    o_valid |-> o_rd_old_rnid == exp_old)
    else report_bad_value("o_rd_old_rnid", 32'($sampled(o_rd_old_rnid)),
                          32'($sampled(exp_old)));
  a_rs1: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    o_valid |-> o_rs1_rnid == exp_rs1)
    else report_bad_value("o_rs1_rnid", 32'($sampled(o_rs1_rnid)), 32'($sampled(exp_rs1)));
  a_rs2: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    o_valid |-> o_rs2_rnid == exp_rs2)
    else report_bad_value("o_rs2_rnid", 32'($sampled(o_rs2_rnid)), 32'($sampled(exp_rs2)));

  // ------------------------------------------------
  // reference model
  // ------------------------------------------------
  function automatic logic ready_now();
    logic exc;
    exc = 1'b0;
    for (int l = 0; l < LANES; l++) begin
      if (i_cmt_valid && i_cmt_kind[l] == CMT_EXCEPT) exc = 1'b1;
    end
    return !(exc || (stg_valid && stg_exc) || rst_pend) &&
           fl_q[0].size() > 0 && fl_q[1].size() > 0;
  endfunction

  task automatic model_step();
    logic [LANES-1:0] wr;
    for (int l = 0; l < LANES; l++) begin
      wr[l] = i_rd_valid[l] && i_rd_idx[l] != '0;
    end
    exp_valid = i_valid && mdl_ready;
    if (exp_valid) begin
      for (int l = 0; l < LANES; l++) begin
        exp_rs1[l] = smap[i_rs1_idx[l]];
        exp_rs2[l] = smap[i_rs2_idx[l]];
        exp_old[l] = smap[i_rd_idx[l]];
        exp_rd[l]  = wr[l] ? rnid_t'(fl_q[l][0]) : '0;
      end
      if (wr[0]) begin  // lane 1 sees lane 0's fresh ID
        if (i_rs1_idx[1] == i_rd_idx[0]) exp_rs1[1] = exp_rd[0];
        if (i_rs2_idx[1] == i_rd_idx[0]) exp_rs2[1] = exp_rd[0];
        if (i_rd_idx[1] == i_rd_idx[0]) exp_old[1] = exp_rd[0];
      end
      for (int l = 0; l < LANES; l++) begin
        if (wr[l]) begin
          void'(fl_q[l].pop_front());
          smap[i_rd_idx[l]] = exp_rd[l];
          out_q[l].push_back({i_rd_idx[l], exp_rd[l], exp_old[l]});
        end
      end
    end
    if (rst_pend) smap = cmap;
    rst_pend = stg_valid && stg_exc;
    if (stg_valid) begin
      for (int l = 0; l < LANES; l++) begin
        if (stg_rdv[l] && stg_rd[l] != '0) begin
          fl_q[l].push_back(int'((stg_kind[l] == CMT_NORMAL) ? stg_old[l] : stg_new[l]));
          if (stg_kind[l] == CMT_NORMAL) cmap[stg_rd[l]] = stg_new[l];
        end
      end
    end
    stg_valid = i_cmt_valid;
    stg_exc   = 1'b0;
    for (int l = 0; l < LANES; l++) begin
      stg_rdv[l]  = i_cmt_rd_valid[l];
      stg_kind[l] = i_cmt_kind[l];
      stg_rd[l]   = i_cmt_rd_idx[l];
      stg_new[l]  = i_cmt_new_rnid[l];
      stg_old[l]  = i_cmt_old_rnid[l];
      if (i_cmt_kind[l] == CMT_EXCEPT) stg_exc = 1'b1;
    end
  endtask

  always @(posedge i_clk) begin
    if (i_reset_n) model_step();
  end

  // ------------------------------------------------
  // stimulus helpers
  // ------------------------------------------------
  task automatic begin_cycle();
    @(negedge i_clk);
    i_valid     = 1'b0;
    i_cmt_valid = 1'b0;
    for (int l = 0; l < LANES; l++) begin
      i_rd_valid[l]     = 1'b0;
      i_rd_idx[l]       = '0;
      i_rs1_idx[l]      = '0;
      i_rs2_idx[l]      = '0;
      i_cmt_rd_valid[l] = 1'b0;
      i_cmt_kind[l]     = CMT_NORMAL;
      i_cmt_rd_idx[l]   = '0;
      i_cmt_new_rnid[l] = '0;
      i_cmt_old_rnid[l] = '0;
    end
  endtask

  task automatic end_cycle();
    mdl_ready = ready_now();
  endtask

  task automatic put_group(input int l, input logic rdv, input int rd, input int rs1,
                           input int rs2);
    i_valid       = 1'b1;
    i_rd_valid[l] = rdv;
    i_rd_idx[l]   = arch_idx_t'(rd);
    i_rs1_idx[l]  = arch_idx_t'(rs1);
    i_rs2_idx[l]  = arch_idx_t'(rs2);
  endtask

  // one cycle with a group whose lanes both name a destination
  task automatic issue_group(input int rd0, input int a0, input int b0,
                             input int rd1, input int a1, input int b1);
    begin_cycle();
    put_group(0, 1'b1, rd0, a0, b0);
    put_group(1, 1'b1, rd1, a1, b1);
    end_cycle();
  endtask

  task automatic put_random_group();
    for (int l = 0; l < LANES; l++) begin
      put_group(l, $urandom_range(3, 0) != 0, $urandom_range(31, 0),
                $urandom_range(31, 0), $urandom_range(31, 0));
    end
  endtask

  // oldest outstanding rename of the lane
  task automatic put_commit(input int l, input cmt_kind_e kind);
    logic [18:0] e;
    if (out_q[l].size() > 0) begin
      e = out_q[l].pop_front();
      i_cmt_valid       = 1'b1;
      i_cmt_rd_valid[l] = 1'b1;
      i_cmt_kind[l]     = kind;
      i_cmt_rd_idx[l]   = e[18:14];
      i_cmt_new_rnid[l] = e[13:7];
      i_cmt_old_rnid[l] = e[6:0];
    end
  endtask

  task automatic commit_cycles(input int n, input cmt_kind_e kind);
    repeat (n) begin
      begin_cycle();
      put_commit(0, kind);
      put_commit(1, kind);
      end_cycle();
    end
  endtask

  // exception on one lane squashes everything younger
  task automatic except_and_drain();
    begin_cycle();
    put_commit((out_q[0].size() > 0) ? 0 : 1, CMT_EXCEPT);
    end_cycle();
    while (out_q[0].size() > 0 || out_q[1].size() > 0) begin
      commit_cycles(1, CMT_DEAD);
    end
  endtask

  // ------------------------------------------------
  // main sequence
  // ------------------------------------------------
  initial begin
    void'($urandom(56907));
    for (int r = 0; r < ARCH_REGS; r++) begin
      smap[r] = rnid_t'(r);
      cmap[r] = rnid_t'(r);
    end
    for (int l = 0; l < LANES; l++) begin
      for (int i = 0; i < FLIST_DEPTH; i++) fl_q[l].push_back(ARCH_REGS + l * FLIST_DEPTH + i);
    end
    stg_valid   = 1'b0;
    stg_exc     = 1'b0;
    rst_pend    = 1'b0;
    mdl_ready   = 1'b1;
    exp_valid   = 1'b0;
    exp_rd      = '0;
    exp_old     = '0;
    exp_rs1     = '0;
    exp_rs2     = '0;
    i_valid     = 1'b0;
    i_cmt_valid = 1'b0;
    i_rd_valid  = '0;
    i_rd_idx    = '0;
    i_rs1_idx   = '0;
    i_rs2_idx   = '0;
    i_cmt_rd_valid = '0;
    i_cmt_kind     = {LANES{CMT_NORMAL}};
    i_cmt_rd_idx   = '0;
    i_cmt_new_rnid = '0;
    i_cmt_old_rnid = '0;
    @(posedge i_reset_n);

    // identity sources and an r0 destination on lane 1
    issue_group(5, 1, 2, 0, 3, 4);
    // in-group dependencies
    issue_group(6, 5, 7, 6, 6, 0);
    issue_group(9, 6, 6, 9, 6, 9);
    commit_cycles(1, CMT_NORMAL);

    // run the free lists dry, then refill them
    repeat (FLIST_DEPTH + 2) begin
      issue_group($urandom_range(31, 1), $urandom_range(31, 0), 9,
                  $urandom_range(31, 1), 6, $urandom_range(31, 0));
    end
    commit_cycles(6, CMT_NORMAL);
    repeat (4) begin
      begin_cycle();
      put_random_group();
      end_cycle();
    end
    commit_cycles(3, CMT_DEAD);
    commit_cycles(2, CMT_NORMAL);
    except_and_drain();
    issue_group(3, 5, 6, 4, 9, 3);

    repeat (N_RANDOM) begin
      if ($urandom_range(29, 0) == 0 && (out_q[0].size() > 0 || out_q[1].size() > 0)) begin
        except_and_drain();
      end else begin
        begin_cycle();
        if ($urandom_range(3, 0) != 0) put_random_group();
        if ($urandom_range(2, 0) == 0) begin
          put_commit(0, ($urandom_range(3, 0) == 0) ? CMT_DEAD : CMT_NORMAL);
          put_commit(1, ($urandom_range(3, 0) == 0) ? CMT_DEAD : CMT_NORMAL);
        end
        end_cycle();
      end
    end
    while (out_q[0].size() > 0 || out_q[1].size() > 0) commit_cycles(1, CMT_NORMAL);
    repeat (4) begin
      begin_cycle();
      end_cycle();
    end

    $display("*** PASSED ***");
    $finish;
  end

  // watchdog
  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired before the test sequence finished");
    $display("*** FAILED ***");
    $fatal(1);
  end

endmodule
